// File: decode_stage.f
+incdir+.
rv_decode_pkg.sv
instr_control_decoder.sv
imm_generator.sv
operand_issue.sv
decode_stage.sv
tb_decode_stage.sv

// File: Makefile
# Verilator build for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_decode_stage
RTL_TOP   ?= decode_stage
FILELIST  ?= decode_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell grep -v '^+' $(FILELIST)) tb_decode_model.svh
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation PASSED" || \
		(echo "simulation FAILED, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_decode_model.svh
// instruction encoders and reference decode rules for the decode stage testbench
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

function automatic word_t enc_r(logic [6:0] f7, reg_idx_t s2, reg_idx_t s1, funct3_t f3,
                                reg_idx_t d, logic [6:0] opc);
  return {f7, s2, s1, f3, d, opc};
endfunction

function automatic word_t enc_i(word_t imm, reg_idx_t s1, funct3_t f3, reg_idx_t d,
                                logic [6:0] opc);
  return {imm[11:0], s1, f3, d, opc};
endfunction

function automatic word_t enc_s(word_t imm, reg_idx_t s2, reg_idx_t s1, funct3_t f3);
  return {imm[11:5], s2, s1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic word_t enc_b(word_t imm, reg_idx_t s2, reg_idx_t s1, funct3_t f3);
  return {imm[12], imm[10:5], s2, s1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic word_t enc_u(word_t imm, reg_idx_t d, logic [6:0] opc);
  return {imm[31:12], d, opc};
endfunction

function automatic word_t enc_j(word_t imm, reg_idx_t d);
  return {imm[20], imm[10:1], imm[11], imm[19:12], d, 7'b1101111};
endfunction

// expected alu op with bit 30 picking SUB or SRA where allowed
function automatic aluop_t ref_aluop(funct3_t f3, logic sub_ok, logic sra_ok);
  case (f3)
    3'd0: return sub_ok ? SUB : ADD;
    3'd1: return SLL;
    3'd2: return SLT;
    3'd3: return SLTU;
    3'd4: return XOR;
    3'd5: return sra_ok ? SRA : SRL;
    3'd6: return OR;
    default: return AND;
  endcase
endfunction

// expected decode/execute bundle for one fetch struct and its register data
function automatic id_ex_t ref_decode(fetch_decode_t f, word_t r1d, word_t r2d);
  id_ex_t e;
  word_t  in;
  word_t  imm_i;
  word_t  imm_s;
  word_t  imm_u;
  logic   shift;
  in    = f.instr;
  imm_i = word_t'($signed(in) >>> 20);
  imm_s = {imm_i[31:5], in[11:7]};
  imm_u = {in[31:12], 12'h000};
  shift = (in[14:12] == 3'd1) || (in[14:12] == 3'd5);
  e = '0;
  e.reg_rs1    = in[19:15];
  e.reg_rs2    = in[24:20];
  e.reg_rd     = in[11:7];
  e.rs1_data   = r1d;
  e.rs2_data   = r2d;
  e.pc         = f.pc;
  e.pc4        = f.pc4;
  e.prediction = f.prediction;
  e.br_imm_sb  = {imm_i[31:12], in[7], in[30:25], in[11:8], 1'b0};
  // zero selects mean rs1_data on both ports and a jump relative to rs1
  e.port_a   = r1d;
  e.port_b   = r1d;
  e.j_base   = r1d;
  e.j_offset = imm_i;
  case (in[6:0])
    7'b0110011: begin
      e.ctrl.alu_b_sel = B_RS2;
      e.ctrl.aluop     = ref_aluop(in[14:12], in[30], in[30]);
      e.ctrl.wen       = 1'b1;
      e.port_b         = r2d;
    end
    7'b0010011: begin
      e.ctrl.alu_b_sel     = B_IMM_SHAMT;
      e.ctrl.aluop         = ref_aluop(in[14:12], 1'b0, in[30]);
      e.ctrl.imm_shamt_sel = shift;
      e.ctrl.wen           = 1'b1;
      e.port_b             = shift ? {27'd0, in[24:20]} : imm_i;
    end
    7'b0110111: begin
      e.ctrl.w_src     = W_IMM_U;
      e.ctrl.lui_instr = 1'b1;
      e.ctrl.wen       = 1'b1;
      e.reg_file_wdata = imm_u;
    end
    7'b0010111: begin
      e.ctrl.alu_a_sel = A_PC;
      e.ctrl.alu_b_sel = B_IMM_U;
      e.ctrl.wen       = 1'b1;
      e.port_a         = f.pc;
      e.port_b         = imm_u;
    end
    7'b1101111, 7'b1100111: begin
      e.ctrl.jump      = 1'b1;
      e.ctrl.j_sel     = in[3];
      e.ctrl.w_src     = W_PC4;
      e.ctrl.wen       = 1'b1;
      e.reg_file_wdata = f.pc4;
      if (in[3]) begin
        e.j_base   = f.pc;
        e.j_offset = {imm_i[31:20], in[19:12], in[20], in[30:21], 1'b0};
      end
    end
    7'b0000011: begin
      e.ctrl.alu_b_sel = B_IMM_SHAMT;
      e.ctrl.dren      = 1'b1;
      e.ctrl.wen       = 1'b1;
      e.ctrl.load_type = in[14:12];
      e.port_b         = imm_i;
    end
    7'b0100011: begin
      e.ctrl.alu_a_sel = A_IMM_S;
      e.ctrl.alu_b_sel = B_RS1;
      e.ctrl.dwen      = 1'b1;
      e.port_a         = imm_s;
    end
    7'b1100011: begin
      e.ctrl.alu_b_sel   = B_RS2;
      e.ctrl.aluop       = SUB;
      e.ctrl.branch      = 1'b1;
      e.ctrl.branch_type = in[14:12];
      e.port_b           = r2d;
    end
    default: e.ctrl.illegal_insn = 1'b1;
  endcase
  return e;
endfunction

`endif

// File: tb_decode_stage.sv
// decode stage testbench with clock, reset, register file model, directed tests and watchdog
`timescale 1ns/1ps

module tb_decode_stage import rv_decode_pkg::*; ();

  `include "tb_decode_model.svh"

  localparam int N_TESTS = 6;

  logic          CLK;
  logic          nRST;
  logic          halt;
  logic          stall;
  logic          id_ex_flush;
  logic          pc_en;
  fetch_decode_t fetch;
  reg_idx_t      rs1;
  reg_idx_t      rs2;
  word_t         rs1_data;
  word_t         rs2_data;
  id_ex_t        id_ex;

  word_t  regs [32];
  integer seed = 22342;
  int     errors;
  int     pass_count;
  int     fail_count;

  decode_stage dut (
    .CLK         (CLK),
    .nRST        (nRST),
    .halt        (halt),
    .stall       (stall),
    .id_ex_flush (id_ex_flush),
    .pc_en       (pc_en),
    .fetch       (fetch),
    .rs1         (rs1),
    .rs2         (rs2),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .id_ex       (id_ex)
  );

  // register file answers in the same cycle
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  initial begin
    #((N_TESTS * 40 + 3) * 10);
    $display("watchdog expired before all tests finished");
    $display("Test failed");
    $finish;
  end

  task automatic check_field(string name, word_t exp, word_t act);
    if (exp !== act) begin
      $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic compare_id_ex(id_ex_t exp);
    check_field("id_ex.ctrl", word_t'(exp.ctrl), word_t'(id_ex.ctrl));
    check_field("id_ex.ctrl.aluop", word_t'(exp.ctrl.aluop), word_t'(id_ex.ctrl.aluop));
    check_field("id_ex.reg_rs1", word_t'(exp.reg_rs1), word_t'(id_ex.reg_rs1));
    check_field("id_ex.reg_rs2", word_t'(exp.reg_rs2), word_t'(id_ex.reg_rs2));
    check_field("id_ex.reg_rd", word_t'(exp.reg_rd), word_t'(id_ex.reg_rd));
    check_field("id_ex.rs1_data", exp.rs1_data, id_ex.rs1_data);
    check_field("id_ex.rs2_data", exp.rs2_data, id_ex.rs2_data);
    check_field("id_ex.port_a", exp.port_a, id_ex.port_a);
    check_field("id_ex.port_b", exp.port_b, id_ex.port_b);
    check_field("id_ex.reg_file_wdata", exp.reg_file_wdata, id_ex.reg_file_wdata);
    check_field("id_ex.j_base", exp.j_base, id_ex.j_base);
    check_field("id_ex.j_offset", exp.j_offset, id_ex.j_offset);
    check_field("id_ex.br_imm_sb", exp.br_imm_sb, id_ex.br_imm_sb);
    check_field("id_ex.pc", exp.pc, id_ex.pc);
    check_field("id_ex.pc4", exp.pc4, id_ex.pc4);
    check_field("id_ex.prediction", word_t'(exp.prediction), word_t'(id_ex.prediction));
  endtask

  function automatic fetch_decode_t make_fetch(word_t instr);
    fetch_decode_t f;
    f.instr      = instr;
    f.pc         = $random(seed) & 32'hffff_fffc;
    f.pc4        = f.pc + 32'd4;
    f.prediction = $random(seed);
    return f;
  endfunction

  function automatic id_ex_t expect_for(fetch_decode_t f);
    return ref_decode(f, regs[f.instr[19:15]], regs[f.instr[24:20]]);
  endfunction

  // drive after one edge so the DUT captures at the next and outputs are sampled mid cycle
  task automatic issue(fetch_decode_t f, logic h, logic s, logic fl, logic en);
    @(posedge CLK);
    fetch       <= f;
    halt        <= h;
    stall       <= s;
    id_ex_flush <= fl;
    pc_en       <= en;
    @(negedge CLK);
    // register file addresses follow the new instruction right away
    check_field("rs1", word_t'(f.instr[19:15]), word_t'(rs1));
    check_field("rs2", word_t'(f.instr[24:20]), word_t'(rs2));
    @(posedge CLK);
    @(negedge CLK);
  endtask

  task automatic decode_check(word_t instr);
    fetch_decode_t f;
    f = make_fetch(instr);
    issue(f, 1'b0, 1'b0, 1'b0, 1'b1);
    compare_id_ex(expect_for(f));
  endtask

  task automatic report(string name, int start_errors);
    if (errors == start_errors) begin
      pass_count++;
      $display("test %s: PASS", name);
    end else begin
      fail_count++;
      $display("test %s: FAIL (%0d errors)", name, errors - start_errors);
    end
  endtask

  task automatic test_reset();
    int e0;
    e0 = errors;
    repeat (3) begin
      @(negedge CLK);
      check_field("id_ex during reset", 32'd0, word_t'(|id_ex));
    end
    @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    check_field("id_ex after reset", 32'd0, word_t'(|id_ex));
    report("reset", e0);
  endtask

  task automatic test_op_alu();
    int       e0;
    word_t    r;
    funct3_t  f3;
    word_t    imm;
    e0 = errors;
    for (int i = 0; i < 8; i++) begin
      r  = $random(seed);
      f3 = r[14:12];
      decode_check(enc_r({1'b0, r[30], 5'd0}, r[24:20], r[19:15], f3, r[11:7], 7'b0110011));
      // shifts take a shamt and the others a signed 12-bit immediate
      if (f3 == 3'd1 || f3 == 3'd5)
        imm = {20'd0, 1'b0, r[30], 5'd0, r[24:20]};
      else
        imm = {{20{r[31]}}, r[31:20]};
      decode_check(enc_i(imm, r[19:15], f3, r[11:7], 7'b0010011));
    end
    decode_check(enc_r(7'h20, 5'd3, 5'd4, 3'd0, 5'd5, 7'b0110011));
    check_field("id_ex.ctrl.aluop sub", word_t'(SUB), word_t'(id_ex.ctrl.aluop));
    decode_check(enc_i(32'h0000_0417, 5'd6, 3'd5, 5'd7, 7'b0010011));
    check_field("id_ex.ctrl.aluop srai", word_t'(SRA), word_t'(id_ex.ctrl.aluop));
    check_field("id_ex.port_b shamt", 32'd23, id_ex.port_b);
    report("op_alu", e0);
  endtask

  task automatic test_mem();
    int e0;
    e0 = errors;
    decode_check(enc_i(32'hffff_fff8, 5'd2, 3'd2, 5'd9, 7'b0000011));
    check_field("id_ex.port_b load", 32'hffff_fff8, id_ex.port_b);
    decode_check(enc_i(32'h0000_07f0, 5'd11, 3'd4, 5'd12, 7'b0000011));
    decode_check(enc_s(32'hffff_ffec, 5'd13, 5'd14, 3'd2));
    check_field("id_ex.port_a store", 32'hffff_ffec, id_ex.port_a);
    decode_check(enc_s(32'h0000_0123, 5'd15, 5'd16, 3'd0));
    decode_check(enc_b(32'hffff_fff0, 5'd17, 5'd18, 3'd1));
    check_field("id_ex.br_imm_sb", 32'hffff_fff0, id_ex.br_imm_sb);
    decode_check(enc_b(32'h0000_0ffe, 5'd19, 5'd20, 3'd6));
    report("mem_branch", e0);
  endtask

  task automatic test_upper_jump();
    int e0;
    e0 = errors;
    decode_check(enc_u(32'habcd_e000, 5'd1, 7'b0110111));
    check_field("id_ex.reg_file_wdata lui", 32'habcd_e000, id_ex.reg_file_wdata);
    decode_check(enc_u(32'h1234_5000, 5'd2, 7'b0010111));
    decode_check(enc_j(32'hffff_fc00, 5'd1));
    check_field("id_ex.j_offset jal", 32'hffff_fc00, id_ex.j_offset);
    decode_check(enc_j(32'h0001_2344, 5'd3));
    decode_check(enc_i(32'hffff_fffc, 5'd8, 3'd0, 5'd1, 7'b1100111));
    check_field("id_ex.j_offset jalr", 32'hffff_fffc, id_ex.j_offset);
    report("upper_jump", e0);
  endtask

  task automatic test_hazard();
    int            e0;
    fetch_decode_t fa;
    fetch_decode_t fb;
    e0 = errors;
    fa = make_fetch(enc_r(7'h00, 5'd21, 5'd22, 3'd6, 5'd23, 7'b0110011));
    fb = make_fetch(enc_i(32'h0000_0055, 5'd24, 3'd0, 5'd25, 7'b0000011));
    issue(fa, 1'b0, 1'b0, 1'b0, 1'b1);
    issue(fb, 1'b0, 1'b0, 1'b0, 1'b0);
    compare_id_ex(expect_for(fa));
    issue(fb, 1'b0, 1'b1, 1'b0, 1'b1);
    compare_id_ex('0);
    issue(fa, 1'b0, 1'b0, 1'b0, 1'b1);
    issue(fb, 1'b0, 1'b0, 1'b1, 1'b1);
    compare_id_ex('0);
    issue(fa, 1'b0, 1'b0, 1'b0, 1'b1);
    issue(fb, 1'b1, 1'b0, 1'b0, 1'b0);
    compare_id_ex('0);
    issue(fb, 1'b0, 1'b0, 1'b0, 1'b1);
    compare_id_ex(expect_for(fb));
    report("hazard", e0);
  endtask

  task automatic test_illegal();
    int e0;
    e0 = errors;
    decode_check(32'h0000_0073);
    check_field("id_ex.ctrl.illegal_insn", 32'd1, word_t'(id_ex.ctrl.illegal_insn));
    check_field("id_ex enables", 32'd0, word_t'({id_ex.ctrl.wen, id_ex.ctrl.dren,
                id_ex.ctrl.dwen, id_ex.ctrl.jump, id_ex.ctrl.branch}));
    decode_check(32'h0ff0_000f);
    report("illegal", e0);
  endtask

  initial begin
    nRST        = 1'b0;
    halt        = 1'b0;
    stall       = 1'b0;
    id_ex_flush = 1'b0;
    pc_en       = 1'b0;
    fetch       = '0;
    errors      = 0;
    pass_count  = 0;
    fail_count  = 0;
    for (int i = 0; i < 32; i++)
      regs[i] = $random(seed);
    test_reset();
    test_op_alu();
    test_mem();
    test_upper_jump();
    test_hazard();
    test_illegal();
    $display("summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
    if (fail_count == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: decode_stage.sv
// decode stage top level wiring the decoder, immediate generator and operand issue
`timescale 1ns/1ps

module decode_stage import rv_decode_pkg::*; (
  input  logic          CLK,
  input  logic          nRST,
  input  logic          halt,
  input  logic          stall,
  input  logic          id_ex_flush,
  input  logic          pc_en,
  input  fetch_decode_t fetch,
  output reg_idx_t      rs1,
  output reg_idx_t      rs2,
  input  word_t         rs1_data,
  input  word_t         rs2_data,
  output id_ex_t        id_ex
);

  decode_ctrl_t ctrl;
  imm_set_t     imms;
  reg_idx_t     rd;

  // rs1/rs2 go straight out to the register file
  instr_control_decoder u_decoder (
    .instr (fetch.instr),
    .ctrl  (ctrl),
    .rs1   (rs1),
    .rs2   (rs2),
    .rd    (rd)
  );

  imm_generator u_imm_gen (
    .instr (fetch.instr),
    .imms  (imms)
  );

  operand_issue u_issue (
    .CLK         (CLK),
    .nRST        (nRST),
    .halt        (halt),
    .stall       (stall),
    .id_ex_flush (id_ex_flush),
    .pc_en       (pc_en),
    .fetch       (fetch),
    .ctrl        (ctrl),
    .imms        (imms),
    .rs1         (rs1),
    .rs2         (rs2),
    .rd          (rd),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .id_ex       (id_ex)
  );

endmodule

// File: operand_issue.sv
// ALU operand, jump and write data selection and the decode/execute register
`timescale 1ns/1ps

module operand_issue import rv_decode_pkg::*; (
  input  logic          CLK,
  input  logic          nRST,
  input  logic          halt,
  input  logic          stall,
  input  logic          id_ex_flush,
  input  logic          pc_en,
  input  fetch_decode_t fetch,
  input  decode_ctrl_t  ctrl,
  input  imm_set_t      imms,
  input  reg_idx_t      rs1,
  input  reg_idx_t      rs2,
  input  reg_idx_t      rd,
  input  word_t         rs1_data,
  input  word_t         rs2_data,
  output id_ex_t        id_ex
);

  word_t  imm_or_shamt;
  word_t  port_a;
  word_t  port_b;
  word_t  w_data;
  word_t  j_base;
  word_t  j_offset;
  logic   bubble;
  logic   load;
  id_ex_t next_id_ex;

  assign imm_or_shamt = ctrl.imm_shamt_sel ? imms.shamt : imms.imm_i;

  always_comb begin
    case (ctrl.alu_a_sel)
      A_RS1:   port_a = rs1_data;
      A_IMM_S: port_a = imms.imm_s;
      A_PC:    port_a = fetch.pc;
      default: port_a = '0;
    endcase
  end

  always_comb begin
    case (ctrl.alu_b_sel)
      B_RS1:       port_b = rs1_data;
      B_RS2:       port_b = rs2_data;
      B_IMM_SHAMT: port_b = imm_or_shamt;
      default:     port_b = imms.imm_u;
    endcase
  end

  // jal is pc relative and jalr register relative
  assign j_base   = ctrl.j_sel ? fetch.pc : rs1_data;
  assign j_offset = ctrl.j_sel ? imms.imm_uj : imms.imm_i;

  always_comb begin
    case (ctrl.w_src)
      W_PC4:   w_data = fetch.pc4;
      W_IMM_U: w_data = imms.imm_u;
      default: w_data = '0;
    endcase
  end

  always_comb begin
    next_id_ex.ctrl           = ctrl;
    next_id_ex.reg_rs1        = rs1;
    next_id_ex.reg_rs2        = rs2;
    next_id_ex.reg_rd         = rd;
    next_id_ex.rs1_data       = rs1_data;
    next_id_ex.rs2_data       = rs2_data;
    next_id_ex.port_a         = port_a;
    next_id_ex.port_b         = port_b;
    next_id_ex.reg_file_wdata = w_data;
    next_id_ex.j_base         = j_base;
    next_id_ex.j_offset       = j_offset;
    next_id_ex.br_imm_sb      = imms.imm_sb;
    next_id_ex.pc             = fetch.pc;
    next_id_ex.pc4            = fetch.pc4;
    next_id_ex.prediction     = fetch.prediction;
  end

  // stall with pc_en inserts a bubble while pc_en low alone holds
  assign bubble = halt | ((id_ex_flush | stall) & pc_en);
  assign load   = pc_en & ~stall;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      id_ex <= '0;
    end else if (bubble) begin
      id_ex <= '0;
    end else if (load) begin
      id_ex <= next_id_ex;
    end
  end

  // the link address handed on must follow the fetched pc
  assert property (@(posedge CLK) disable iff (!nRST)
    load && !bubble |-> fetch.pc4 == fetch.pc + 32'd4)
    else $error("fetch pc4 %h does not follow pc %h", fetch.pc4, fetch.pc);

endmodule

// File: imm_generator.sv
// sign-extended I, S, SB, U and UJ immediates and the shift amount
`timescale 1ns/1ps

module imm_generator import rv_decode_pkg::*; (
  input  word_t    instr,
  output imm_set_t imms
);

  // bit 31 is the sign for every format
  logic sign;

  assign sign = instr[31];

  always_comb begin
    imms.imm_i = {{20{sign}}, instr[31:20]};

    imms.imm_s = {{20{sign}}, instr[31:25], instr[11:7]};

    // halfword aligned branch offset
    imms.imm_sb = {{19{sign}}, instr[31], instr[7], instr[30:25],
                   instr[11:8], 1'b0};

    // upper immediate already in place
    imms.imm_u = {instr[31:12], 12'b0};

    // halfword aligned jal offset
    imms.imm_uj = {{11{sign}}, instr[31], instr[19:12], instr[20],
                   instr[30:21], 1'b0};

    // shamt is unsigned
    imms.shamt = {27'b0, instr[24:20]};
  end

endmodule

// File: instr_control_decoder.sv
// opcode and funct decoding into the control struct and register indices
`timescale 1ns/1ps

module instr_control_decoder import rv_decode_pkg::*; (
  input  word_t        instr,
  output decode_ctrl_t ctrl,
  output reg_idx_t     rs1,
  output reg_idx_t     rs2,
  output reg_idx_t     rd
);

  opcode_t opcode;
  funct3_t funct3;
  logic    bit30;

  // shared by OP and OP-IMM with bit 30 gating from the caller
  function automatic aluop_t funct_aluop(funct3_t f3, logic sub_en, logic sra_en);
    aluop_t op;
    case (f3)
      3'b000:  op = sub_en ? SUB : ADD;
      3'b001:  op = SLL;
      3'b010:  op = SLT;
      3'b011:  op = SLTU;
      3'b100:  op = XOR;
      3'b101:  op = sra_en ? SRA : SRL;
      3'b110:  op = OR;
      default: op = AND;
    endcase
    return op;
  endfunction

  assign opcode = opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign bit30  = instr[30];

  // register fields sit in fixed places for every format
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];
  assign rd  = instr[11:7];

  always_comb begin
    ctrl = '0;
    case (opcode)
      OP: begin
        ctrl.alu_a_sel = A_RS1;
        ctrl.alu_b_sel = B_RS2;
        ctrl.aluop     = funct_aluop(funct3, bit30, bit30);
        ctrl.wen       = 1'b1;
      end
      OP_IMM: begin
        ctrl.alu_a_sel     = A_RS1;
        ctrl.alu_b_sel     = B_IMM_SHAMT;
        // bit 30 only picks the arithmetic shift since there is no SUBI
        ctrl.aluop         = funct_aluop(funct3, 1'b0, bit30);
        ctrl.imm_shamt_sel = (funct3 == 3'b001) || (funct3 == 3'b101);
        ctrl.wen           = 1'b1;
      end
      LUI: begin
        ctrl.w_src     = W_IMM_U;
        ctrl.lui_instr = 1'b1;
        ctrl.wen       = 1'b1;
      end
      AUIPC: begin
        ctrl.alu_a_sel = A_PC;
        ctrl.alu_b_sel = B_IMM_U;
        ctrl.aluop     = ADD;
        ctrl.wen       = 1'b1;
      end
      JAL: begin
        ctrl.jump  = 1'b1;
        ctrl.j_sel = 1'b1;
        ctrl.w_src = W_PC4;
        ctrl.wen   = 1'b1;
      end
      JALR: begin
        ctrl.jump  = 1'b1;
        ctrl.w_src = W_PC4;
        ctrl.wen   = 1'b1;
      end
      LOAD: begin
        ctrl.alu_a_sel = A_RS1;
        ctrl.alu_b_sel = B_IMM_SHAMT;
        ctrl.aluop     = ADD;
        ctrl.dren      = 1'b1;
        ctrl.wen       = 1'b1;
        ctrl.load_type = funct3;
      end
      STORE: begin
        // address is imm_s + rs1 and the store data is rs2_data downstream
        ctrl.alu_a_sel = A_IMM_S;
        ctrl.alu_b_sel = B_RS1;
        ctrl.aluop     = ADD;
        ctrl.dwen      = 1'b1;
      end
      BRANCH: begin
        ctrl.alu_a_sel   = A_RS1;
        ctrl.alu_b_sel   = B_RS2;
        ctrl.aluop       = SUB;
        ctrl.branch      = 1'b1;
        ctrl.branch_type = funct3;
      end
      default: ctrl.illegal_insn = 1'b1;
    endcase
  end

endmodule

// File: rv_decode_pkg.sv
// widths, opcode and selector enums, fetch/control/immediate/decode-execute structs
package rv_decode_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [2:0]  funct3_t;

  // RV32I major opcodes handled by this stage
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011
  } opcode_t;

  typedef enum logic [1:0] {A_RS1, A_IMM_S, A_PC, A_ZERO} alu_a_sel_t;
  typedef enum logic [1:0] {B_RS1, B_RS2, B_IMM_SHAMT, B_IMM_U} alu_b_sel_t;
  typedef enum logic [1:0] {W_ALU = 2'd0, W_PC4 = 2'd1, W_IMM_U = 2'd2} w_src_t;

  // ADD is zero so a bubble carries a harmless op
  typedef enum logic [3:0] {ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND} aluop_t;

  typedef struct packed {
    word_t instr;
    word_t pc;
    word_t pc4;
    logic  prediction;
  } fetch_decode_t;

  typedef struct packed {
    alu_a_sel_t alu_a_sel;
    alu_b_sel_t alu_b_sel;
    w_src_t     w_src;
    aluop_t     aluop;
    logic       wen;
    logic       dren;
    logic       dwen;
    logic       jump;
    logic       j_sel;
    logic       branch;
    funct3_t    load_type;
    funct3_t    branch_type;
    logic       imm_shamt_sel;
    logic       lui_instr;
    logic       illegal_insn;
  } decode_ctrl_t;

  typedef struct packed {
    word_t imm_i;
    word_t imm_s;
    word_t imm_sb;
    word_t imm_u;
    word_t imm_uj;
    word_t shamt;
  } imm_set_t;

  typedef struct packed {
    decode_ctrl_t ctrl;
    reg_idx_t     reg_rs1;
    reg_idx_t     reg_rs2;
    reg_idx_t     reg_rd;
    word_t        rs1_data;
    word_t        rs2_data;
    word_t        port_a;
    word_t        port_b;
    word_t        reg_file_wdata;
    word_t        j_base;
    word_t        j_offset;
    word_t        br_imm_sb;
    word_t        pc;
    word_t        pc4;
    logic         prediction;
  } id_ex_t;

endpackage
